// ==== design/autotest_macros.svh ====
// **********************************************************************
// widths, record layout, signature and start address for the
// cipher self-test sequencer
// **********************************************************************

`ifndef AUTOTEST_MACROS_SVH
`define AUTOTEST_MACROS_SVH

`define AT_BLOCK_W        64
`define AT_KEY_W          80
`define AT_ADDR_W         32
`define AT_BYTE_CNT_W     10
`define AT_TIMER_W        64
`define AT_ERR_W          32

`define AT_SD_BLOCK_BYTES 512
`define AT_SIGNATURE      32'hAABBCCDD
`define AT_START_BLOCK    32'h0010_0000

// record read offsets
`define AT_OFS_BLOCK      5
`define AT_OFS_KEY        13
`define AT_OFS_DIR        23
`define AT_OFS_EXPECT     24

// write-back offsets
`define AT_OFS_RESULT     32
`define AT_OFS_TIME       40
`define AT_OFS_END        48

`endif

// ==== design/autotest_pkg.sv ====
// **********************************************************************
// sequencer FSM state encoding and debug view select
// **********************************************************************

package autotest_pkg;

  typedef enum logic [4:0] {
    INIT           = 5'd0,
    SPI_RESET      = 5'd1,
    SPI_RESET_WAIT = 5'd2,
    IDLE           = 5'd3,
    RD_OPEN        = 5'd4,
    RD_OPEN_WAIT   = 5'd5,
    RD_BYTE_REQ    = 5'd6,
    RD_BYTE_WAIT   = 5'd7,
    CHECK_SIG      = 5'd8,
    RUN            = 5'd9,
    WAIT_DONE      = 5'd10,
    CAPTURE        = 5'd11,
    COMPARE        = 5'd12,
    WR_OPEN        = 5'd13,
    WR_OPEN_WAIT   = 5'd14,
    WR_BYTE_REQ    = 5'd15,
    WR_BYTE_WAIT   = 5'd16,
    NEXT_BLOCK     = 5'd17,
    HALT           = 5'd18
  } ctrl_state_e;

  typedef enum logic [1:0] {
    DBG_STATUS  = 2'd0,
    DBG_ERRORS  = 2'd1,
    DBG_TIME_LO = 2'd2,
    DBG_TIME_HI = 2'd3
  } dbg_sel_e;

endpackage

// ==== design/vector_store.sv ====
// **********************************************************************
// test vector registers loaded from the SD record, UUT result capture,
// expected/result comparison and write-back byte selection
// **********************************************************************

`timescale 1ns/10ps
`include "autotest_macros.svh"

module vector_store (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [7:0]                spi_data_i,
  input  logic [`AT_BYTE_CNT_W-1:0] byte_cnt_i,
  input  logic                      load_en_i,
  input  logic                      clear_i,
  input  logic                      capture_en_i,
  input  logic [`AT_BLOCK_W-1:0]    uut_result_i,
  input  logic [`AT_TIMER_W-1:0]    exec_time_i,
  output logic [`AT_BLOCK_W-1:0]    block_o,
  output logic [`AT_KEY_W-1:0]      key_o,
  output logic                      decrypt_o,
  output logic                      signature_ok_o,
  output logic                      mismatch_o,
  output logic [7:0]                wr_byte_o
);

  localparam int CW         = `AT_BYTE_CNT_W;
  localparam int BLK_BYTES  = `AT_BLOCK_W / 8;
  localparam int KEY_BYTES  = `AT_KEY_W / 8;
  localparam int TIME_BYTES = `AT_TIMER_W / 8;

  logic [31:0]             sig_q;
  logic [`AT_BLOCK_W-1:0]  blk_q;
  logic [`AT_KEY_W-1:0]    key_q;
  logic                    dec_q;
  logic [`AT_BLOCK_W-1:0]  exp_q;
  logic [`AT_BLOCK_W-1:0]  res_q;

  // signature arrives msb first, other fields lsb first
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      sig_q <= '0;
    end else if (load_en_i) begin
      for (int k = 0; k < 4; k++) begin
        if (byte_cnt_i == CW'(k)) begin
          sig_q[31-8*k -: 8] <= spi_data_i;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clear_i) begin
      blk_q <= '0;
      key_q <= '0;
      dec_q <= 1'b0;
      exp_q <= '0;
      res_q <= '0;
    end else begin
      if (load_en_i) begin
        for (int k = 0; k < BLK_BYTES; k++) begin
          if (byte_cnt_i == CW'(`AT_OFS_BLOCK + k)) begin
            blk_q[8*k +: 8] <= spi_data_i;
          end
          if (byte_cnt_i == CW'(`AT_OFS_EXPECT + k)) begin
            exp_q[8*k +: 8] <= spi_data_i;
          end
        end
        for (int k = 0; k < KEY_BYTES; k++) begin
          if (byte_cnt_i == CW'(`AT_OFS_KEY + k)) begin
            key_q[8*k +: 8] <= spi_data_i;
          end
        end
        if (byte_cnt_i == CW'(`AT_OFS_DIR)) begin
          dec_q <= spi_data_i[0];
        end
      end
      if (capture_en_i) begin
        res_q <= uut_result_i;
      end
    end
  end

  // write-back byte for the current offset, FF where nothing is stored
  always_comb begin
    wr_byte_o = 8'hFF;
    for (int k = 0; k < 4; k++) begin
      if (byte_cnt_i == CW'(k)) begin
        wr_byte_o = sig_q[31-8*k -: 8];
      end
    end
    for (int k = 0; k < BLK_BYTES; k++) begin
      if (byte_cnt_i == CW'(`AT_OFS_BLOCK + k)) begin
        wr_byte_o = blk_q[8*k +: 8];
      end
      if (byte_cnt_i == CW'(`AT_OFS_EXPECT + k)) begin
        wr_byte_o = exp_q[8*k +: 8];
      end
      if (byte_cnt_i == CW'(`AT_OFS_RESULT + k)) begin
        wr_byte_o = res_q[8*k +: 8];
      end
    end
    for (int k = 0; k < KEY_BYTES; k++) begin
      if (byte_cnt_i == CW'(`AT_OFS_KEY + k)) begin
        wr_byte_o = key_q[8*k +: 8];
      end
    end
    for (int k = 0; k < TIME_BYTES; k++) begin
      if (byte_cnt_i == CW'(`AT_OFS_TIME + k)) begin
        wr_byte_o = exec_time_i[8*k +: 8];
      end
    end
    if (byte_cnt_i == CW'(`AT_OFS_DIR)) begin
      wr_byte_o = {7'd0, dec_q};
    end
  end

  assign block_o        = blk_q;
  assign key_o          = key_q;
  assign decrypt_o      = dec_q;
  assign signature_ok_o = (sig_q == `AT_SIGNATURE);
  assign mismatch_o     = (res_q != exp_q);

endmodule

// ==== design/autotest_ctrl.sv ====
// **********************************************************************
// self-test sequencing FSM: SD block read, signature check, UUT run,
// compare and failure write-back; byte, block, error and exec timer
// counters; debug view multiplexer
// **********************************************************************

`timescale 1ns/10ps
`include "autotest_macros.svh"

module autotest_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      spi_busy_i,
  output logic                      spi_rst_o,
  output logic                      spi_r_block_o,
  output logic                      spi_r_byte_o,
  output logic                      spi_w_block_o,
  output logic                      spi_w_byte_o,
  output logic [`AT_ADDR_W-1:0]     spi_block_addr_o,
  output logic [7:0]                spi_data_o,
  output logic                      uut_rst_o,
  input  logic                      uut_decrypt_i,
  input  logic                      uut_end_enc_i,
  input  logic                      uut_end_dec_i,
  input  logic                      signature_ok_i,
  input  logic                      mismatch_i,
  input  logic [7:0]                wr_byte_i,
  output logic [`AT_BYTE_CNT_W-1:0] byte_cnt_o,
  output logic                      load_en_o,
  output logic                      clear_o,
  output logic                      capture_en_o,
  output logic [`AT_TIMER_W-1:0]    exec_time_o,
  input  autotest_pkg::dbg_sel_e    dbg_sel_i,
  output logic [31:0]               dbg_o
);

  localparam int CW = `AT_BYTE_CNT_W;
  localparam logic [CW-1:0] LAST_BYTE = CW'(`AT_SD_BLOCK_BYTES - 1);
  localparam logic [CW-1:0] END_CNT   = CW'(`AT_SD_BLOCK_BYTES);

  autotest_pkg::ctrl_state_e state_q;
  autotest_pkg::ctrl_state_e state_d;

  logic [CW-1:0]             byte_cnt_q;
  logic [`AT_ADDR_W-1:0]     addr_q;
  logic [`AT_ERR_W-1:0]      err_q;
  logic [`AT_TIMER_W-1:0]    timer_q;
  logic [7:0]                data_q;

  logic cnt_clr;
  logic cnt_inc;
  logic addr_inc;
  logic err_inc;
  logic timer_clr;
  logic timer_inc;
  logic uut_done;

  // completion level of the loaded direction
  assign uut_done = uut_decrypt_i ? uut_end_dec_i : uut_end_enc_i;

  always_comb begin
    state_d       = state_q;
    spi_rst_o     = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o  = 1'b0;
    uut_rst_o     = 1'b1;
    load_en_o     = 1'b0;
    clear_o       = 1'b0;
    capture_en_o  = 1'b0;
    cnt_clr       = 1'b0;
    cnt_inc       = 1'b0;
    addr_inc      = 1'b0;
    err_inc       = 1'b0;
    timer_clr     = 1'b0;
    timer_inc     = 1'b0;
    case (state_q)
      autotest_pkg::INIT: begin
        state_d = autotest_pkg::SPI_RESET;
      end
      autotest_pkg::SPI_RESET: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) begin
          state_d = autotest_pkg::SPI_RESET_WAIT;
        end
      end
      autotest_pkg::SPI_RESET_WAIT: begin
        if (!spi_busy_i) begin
          state_d = autotest_pkg::IDLE;
        end
      end
      autotest_pkg::IDLE: begin
        clear_o   = 1'b1;
        cnt_clr   = 1'b1;
        timer_clr = 1'b1;
        if (!spi_busy_i) begin
          state_d = autotest_pkg::RD_OPEN;
        end
      end
      autotest_pkg::RD_OPEN: begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i) begin
          state_d = autotest_pkg::RD_OPEN_WAIT;
        end
      end
      autotest_pkg::RD_OPEN_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          state_d = autotest_pkg::RD_BYTE_REQ;
        end
      end
      autotest_pkg::RD_BYTE_REQ: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) begin
          state_d = autotest_pkg::RD_BYTE_WAIT;
        end
      end
      autotest_pkg::RD_BYTE_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          // read data is valid as busy falls
          load_en_o = 1'b1;
          cnt_inc   = 1'b1;
          if (byte_cnt_q == LAST_BYTE) begin
            state_d = autotest_pkg::CHECK_SIG;
          end else begin
            state_d = autotest_pkg::RD_BYTE_REQ;
          end
        end
      end
      autotest_pkg::CHECK_SIG: begin
        if (signature_ok_i) begin
          state_d = autotest_pkg::RUN;
        end else begin
          state_d = autotest_pkg::HALT;
        end
      end
      autotest_pkg::RUN: begin
        uut_rst_o = 1'b0;
        state_d   = autotest_pkg::WAIT_DONE;
      end
      autotest_pkg::WAIT_DONE: begin
        uut_rst_o = 1'b0;
        timer_inc = 1'b1;
        if (uut_done) begin
          state_d = autotest_pkg::CAPTURE;
        end
      end
      autotest_pkg::CAPTURE: begin
        uut_rst_o    = 1'b0;
        capture_en_o = 1'b1;
        state_d      = autotest_pkg::COMPARE;
      end
      autotest_pkg::COMPARE: begin
        uut_rst_o = 1'b0;
        if (mismatch_i) begin
          err_inc = 1'b1;
          cnt_clr = 1'b1;
          state_d = autotest_pkg::WR_OPEN;
        end else begin
          state_d = autotest_pkg::NEXT_BLOCK;
        end
      end
      autotest_pkg::WR_OPEN: begin
        uut_rst_o     = 1'b0;
        spi_w_block_o = 1'b1;
        if (spi_busy_i) begin
          state_d = autotest_pkg::WR_OPEN_WAIT;
        end
      end
      autotest_pkg::WR_OPEN_WAIT: begin
        uut_rst_o     = 1'b0;
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          state_d = autotest_pkg::WR_BYTE_REQ;
        end
      end
      autotest_pkg::WR_BYTE_REQ: begin
        uut_rst_o     = 1'b0;
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i) begin
          cnt_inc = 1'b1;
          state_d = autotest_pkg::WR_BYTE_WAIT;
        end
      end
      autotest_pkg::WR_BYTE_WAIT: begin
        uut_rst_o     = 1'b0;
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          if (byte_cnt_q == END_CNT) begin
            state_d = autotest_pkg::NEXT_BLOCK;
          end else begin
            state_d = autotest_pkg::WR_BYTE_REQ;
          end
        end
      end
      autotest_pkg::NEXT_BLOCK: begin
        addr_inc = 1'b1;
        state_d  = autotest_pkg::IDLE;
      end
      default: begin
        // HALT, stays here until reset
        state_d = autotest_pkg::HALT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= autotest_pkg::INIT;
      byte_cnt_q <= '0;
      addr_q     <= `AT_START_BLOCK;
      err_q      <= '0;
      timer_q    <= '0;
    end else begin
      state_q <= state_d;
      if (cnt_clr) begin
        byte_cnt_q <= '0;
      end else if (cnt_inc) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
      if (addr_inc) begin
        addr_q <= addr_q + 1'b1;
      end
      if (err_inc) begin
        err_q <= err_q + 1'b1;
      end
      if (timer_clr) begin
        timer_q <= '0;
      end else if (timer_inc) begin
        timer_q <= timer_q + 1'b1;
      end
    end
  end

  // write data follows the byte counter, frozen while w_byte is held
  always_ff @(posedge clk) begin
    if (state_q != autotest_pkg::WR_BYTE_REQ) begin
      data_q <= wr_byte_i;
    end
  end

  always_comb begin
    dbg_o = '0;
    case (dbg_sel_i)
      autotest_pkg::DBG_STATUS:  dbg_o = {addr_q[15:0], 11'd0, state_q};
      autotest_pkg::DBG_ERRORS:  dbg_o = err_q;
      autotest_pkg::DBG_TIME_LO: dbg_o = timer_q[31:0];
      autotest_pkg::DBG_TIME_HI: dbg_o = timer_q[63:32];
      default:                   dbg_o = '0;
    endcase
  end

  assign spi_block_addr_o = addr_q;
  assign spi_data_o       = data_q;
  assign byte_cnt_o       = byte_cnt_q;
  assign exec_time_o      = timer_q;

endmodule

// ==== design/autotest_top.sv ====
// **********************************************************************
// self-test sequencer top level: controller and vector store
// between the SPI host and the cipher under test
// **********************************************************************

`timescale 1ns/10ps
`include "autotest_macros.svh"

module autotest_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spi_busy_i,
  input  logic [7:0]             spi_data_i,
  output logic                   spi_rst_o,
  output logic                   spi_r_block_o,
  output logic                   spi_r_byte_o,
  output logic                   spi_w_block_o,
  output logic                   spi_w_byte_o,
  output logic [`AT_ADDR_W-1:0]  spi_block_addr_o,
  output logic [7:0]             spi_data_o,
  output logic                   uut_rst_o,
  output logic [`AT_BLOCK_W-1:0] uut_block_o,
  output logic [`AT_KEY_W-1:0]   uut_key_o,
  output logic                   uut_decrypt_o,
  input  logic [`AT_BLOCK_W-1:0] uut_result_i,
  input  logic                   uut_end_enc_i,
  input  logic                   uut_end_dec_i,
  input  autotest_pkg::dbg_sel_e dbg_sel_i,
  output logic [31:0]            dbg_o
);

  logic [`AT_BYTE_CNT_W-1:0] byte_cnt;
  logic                      load_en;
  logic                      clear;
  logic                      capture_en;
  logic [`AT_TIMER_W-1:0]    exec_time;
  logic                      signature_ok;
  logic                      mismatch;
  logic [7:0]                wr_byte;

  autotest_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .spi_rst_o        (spi_rst_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_w_block_o    (spi_w_block_o),
    .spi_w_byte_o     (spi_w_byte_o),
    .spi_block_addr_o (spi_block_addr_o),
    .spi_data_o       (spi_data_o),
    .uut_rst_o        (uut_rst_o),
    .uut_decrypt_i    (uut_decrypt_o),
    .uut_end_enc_i    (uut_end_enc_i),
    .uut_end_dec_i    (uut_end_dec_i),
    .signature_ok_i   (signature_ok),
    .mismatch_i       (mismatch),
    .wr_byte_i        (wr_byte),
    .byte_cnt_o       (byte_cnt),
    .load_en_o        (load_en),
    .clear_o          (clear),
    .capture_en_o     (capture_en),
    .exec_time_o      (exec_time),
    .dbg_sel_i        (dbg_sel_i),
    .dbg_o            (dbg_o)
  );

  vector_store u_store (
    .clk            (clk),
    .rst            (rst),
    .spi_data_i     (spi_data_i),
    .byte_cnt_i     (byte_cnt),
    .load_en_i      (load_en),
    .clear_i        (clear),
    .capture_en_i   (capture_en),
    .uut_result_i   (uut_result_i),
    .exec_time_i    (exec_time),
    .block_o        (uut_block_o),
    .key_o          (uut_key_o),
    .decrypt_o      (uut_decrypt_o),
    .signature_ok_o (signature_ok),
    .mismatch_o     (mismatch),
    .wr_byte_o      (wr_byte)
  );

endmodule

// ==== testbench/sd_host_model.sv ====
// **********************************************************************
// behavioral SPI host over an array of SD blocks, busy-level protocol
// **********************************************************************

`timescale 1ns/10ps
`include "autotest_macros.svh"

module sd_host_model #(
  parameter int NBLK = 8
) (
  input  logic                  clk,
  input  logic                  spi_rst_i,
  input  logic                  r_block_i,
  input  logic                  r_byte_i,
  input  logic                  w_block_i,
  input  logic                  w_byte_i,
  input  logic [`AT_ADDR_W-1:0] block_addr_i,
  input  logic [7:0]            data_i,
  output logic                  busy_o,
  output logic [7:0]            data_o
);

  logic [7:0] mem [NBLK][`AT_SD_BLOCK_BYTES];
  logic [7:0] rd_data;
  logic       rd_open;
  logic       wr_open;
  int         idx;
  int         hold;
  int         blk;

  initial begin
    busy_o  = 1'b0;
    data_o  = 8'h00;
    rd_data = 8'h00;
    rd_open = 1'b0;
    wr_open = 1'b0;
    idx     = 0;
    hold    = 0;
  end

  // commands are sampled once the DUT outputs have settled
  always @(posedge clk) begin
    #1;
    blk = int'(block_addr_i - `AT_START_BLOCK) % NBLK;
    if (busy_o) begin
      hold = hold - 1;
      if (hold == 0) begin
        busy_o = 1'b0;
        data_o = rd_data;
      end
    end else begin
      hold = 1 + (idx % 3);
      if (spi_rst_i) begin
        busy_o = 1'b1;
      end else if (r_block_i && !rd_open) begin
        rd_open = 1'b1;
        idx     = 0;
        busy_o  = 1'b1;
      end else if (r_byte_i) begin
        rd_data = mem[blk][idx];
        idx     = idx + 1;
        busy_o  = 1'b1;
      end else if (w_block_i && !wr_open) begin
        wr_open = 1'b1;
        idx     = 0;
        busy_o  = 1'b1;
      end else if (w_byte_i) begin
        mem[blk][idx] = data_i;
        idx           = idx + 1;
        busy_o        = 1'b1;
      end
    end
    if (!r_block_i) begin
      rd_open = 1'b0;
    end
    if (!w_block_i) begin
      wr_open = 1'b0;
    end
  end

endmodule

// ==== testbench/autotest_props.sv ====
// **********************************************************************
// concurrent assertions on the sequencer top level: bring-up,
// first read address, halt and read/write exclusion
// **********************************************************************

`timescale 1ns/10ps
`include "autotest_macros.svh"

module autotest_props (
  input logic                      clk,
  input logic                      rst,
  input logic                      spi_busy_i,
  input logic                      spi_rst_o,
  input logic                      spi_r_block_o,
  input logic                      spi_r_byte_o,
  input logic                      spi_w_block_o,
  input logic                      spi_w_byte_o,
  input logic [`AT_ADDR_W-1:0]     spi_block_addr_o,
  input logic                      uut_rst_o,
  input autotest_pkg::ctrl_state_e state_i
);

  logic rst_done;
  logic seen_read;

  always_ff @(posedge clk) begin
    if (rst) begin
      rst_done  <= 1'b0;
      seen_read <= 1'b0;
    end else begin
      if (state_i == autotest_pkg::SPI_RESET_WAIT && !spi_busy_i) begin
        rst_done <= 1'b1;
      end
      if (spi_r_block_o) begin
        seen_read <= 1'b1;
      end
    end
  end

  spi_rst_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !spi_rst_o ##1 spi_rst_o)
    else $error("spi reset did not follow the release of reset");

  no_access_before_bringup: assert property (@(posedge clk) disable iff (rst)
    !rst_done |-> !(spi_r_block_o || spi_r_byte_o || spi_w_block_o || spi_w_byte_o))
    else $error("SD access before the host finished its reset");

  first_read_address: assert property (@(posedge clk) disable iff (rst)
    (spi_r_block_o && !seen_read) |-> spi_block_addr_o == `AT_START_BLOCK)
    else $error("first read is not at the start block");

  halt_is_quiet: assert property (@(posedge clk) disable iff (rst)
    state_i == autotest_pkg::HALT |=> state_i == autotest_pkg::HALT && uut_rst_o &&
      !(spi_rst_o || spi_r_block_o || spi_r_byte_o || spi_w_block_o || spi_w_byte_o))
    else $error("activity after halt");

  read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
    !((spi_r_block_o || spi_r_byte_o) && (spi_w_block_o || spi_w_byte_o)))
    else $error("read and write strobes high together");

endmodule

bind autotest_top autotest_props u_props (
  .clk              (clk),
  .rst              (rst),
  .spi_busy_i       (spi_busy_i),
  .spi_rst_o        (spi_rst_o),
  .spi_r_block_o    (spi_r_block_o),
  .spi_r_byte_o     (spi_r_byte_o),
  .spi_w_block_o    (spi_w_block_o),
  .spi_w_byte_o     (spi_w_byte_o),
  .spi_block_addr_o (spi_block_addr_o),
  .uut_rst_o        (uut_rst_o),
  .state_i          (u_ctrl.state_q)
);

// ==== testbench/tb_autotest.sv ====
// **********************************************************************
// testbench for the self-test sequencer: clock, reset, SD host and
// UUT models, vector generation, operand and write-back checks
// **********************************************************************

`timescale 1ns/10ps
`include "autotest_macros.svh"

module tb_autotest;

  localparam int NVEC           = 6;
  localparam int TIMEOUT_CYCLES = 40000;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   spi_busy;
  logic [7:0]             spi_rdata;
  logic                   spi_rst;
  logic                   spi_r_block;
  logic                   spi_r_byte;
  logic                   spi_w_block;
  logic                   spi_w_byte;
  logic [`AT_ADDR_W-1:0]  spi_addr;
  logic [7:0]             spi_wdata;
  logic                   uut_rst;
  logic [`AT_BLOCK_W-1:0] uut_block;
  logic [`AT_KEY_W-1:0]   uut_key;
  logic                   uut_decrypt;
  logic [`AT_BLOCK_W-1:0] uut_result;
  logic                   uut_end_enc;
  logic                   uut_end_dec;
  autotest_pkg::dbg_sel_e dbg_sel;
  logic [31:0]            dbg;

  logic [`AT_BLOCK_W-1:0] blk_v [NVEC];
  logic [`AT_KEY_W-1:0]   key_v [NVEC];
  logic                   dec_v [NVEC];
  logic [`AT_BLOCK_W-1:0] exp_v [NVEC];
  logic                   bad_exp [NVEC];
  int                     dly_v [NVEC];
  logic [7:0]             rec [NVEC][32];
  int vec_idx;
  int run_cnt;
  int cycle_cnt;
  int wr_blocks;
  int err_total;
  int fail_cnt;
  logic w_block_d;

  always #4 clk = ~clk;

  autotest_top u_autotest_top (
    .clk (clk), .rst (rst),
    .spi_busy_i (spi_busy), .spi_data_i (spi_rdata),
    .spi_rst_o (spi_rst), .spi_r_block_o (spi_r_block), .spi_r_byte_o (spi_r_byte),
    .spi_w_block_o (spi_w_block), .spi_w_byte_o (spi_w_byte),
    .spi_block_addr_o (spi_addr), .spi_data_o (spi_wdata),
    .uut_rst_o (uut_rst), .uut_block_o (uut_block), .uut_key_o (uut_key),
    .uut_decrypt_o (uut_decrypt), .uut_result_i (uut_result),
    .uut_end_enc_i (uut_end_enc), .uut_end_dec_i (uut_end_dec),
    .dbg_sel_i (dbg_sel), .dbg_o (dbg)
  );

  sd_host_model #(.NBLK(8)) u_sd (
    .clk (clk), .spi_rst_i (spi_rst), .r_block_i (spi_r_block), .r_byte_i (spi_r_byte),
    .w_block_i (spi_w_block), .w_byte_i (spi_w_byte), .block_addr_i (spi_addr),
    .data_i (spi_wdata), .busy_o (spi_busy), .data_o (spi_rdata)
  );

  // toy cipher xors the block with the low key half and a decrypt mask
  function automatic logic [63:0] cipher_model(input logic [63:0] b, input logic [79:0] k,
                                               input logic d);
    cipher_model = b ^ k[63:0] ^ (d ? 64'h5A5A_5A5A_5A5A_5A5A : 64'h0);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp_val,
                                 input logic [127:0] act_val);
    fail_cnt++;
    $display("MISMATCH %s expected %h actual %h", name, exp_val, act_val);
    $display("TEST FAIL");
    $fatal(1, "check failed");
  endtask

  // UUT model raises its end level some cycles after its reset falls
  always @(posedge clk) begin
    #1;
    if (uut_rst) begin
      run_cnt     = 0;
      uut_end_enc = 1'b0;
      uut_end_dec = 1'b0;
    end else begin
      if (run_cnt == dly_v[vec_idx]) begin
        uut_result  = cipher_model(uut_block, uut_key, uut_decrypt);
        uut_end_enc = !uut_decrypt;
        uut_end_dec = uut_decrypt;
      end
      run_cnt = run_cnt + 1;
    end
  end

  always @(posedge clk) begin
    #1;
    if (spi_w_block && !w_block_d) begin
      wr_blocks = wr_blocks + 1;
    end
    w_block_d = spi_w_block;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the sequencer did not reach halt in %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic build_vectors();
    logic [63:0] res;
    for (int v = 0; v < NVEC; v++) begin
      blk_v[v]   = {$urandom, $urandom};
      key_v[v]   = {16'($urandom), $urandom, $urandom};
      dec_v[v]   = 1'($urandom);
      dly_v[v]   = 3 + int'($urandom % 18);
      bad_exp[v] = (v == 1) || (v == 3);
      res        = cipher_model(blk_v[v], key_v[v], dec_v[v]);
      exp_v[v]   = bad_exp[v] ? res ^ {32'h0, $urandom | 32'h1} : res;
      for (int i = 0; i < 4; i++) begin
        rec[v][i] = 8'(`AT_SIGNATURE >> (24 - 8 * i));
      end
      // last vector carries a broken signature
      if (v == NVEC - 1) begin
        rec[v][3] = rec[v][3] ^ 8'h01;
      end
      rec[v][4] = 8'hFF;
      for (int i = 0; i < 8; i++) begin
        rec[v][`AT_OFS_BLOCK + i]  = blk_v[v][8*i +: 8];
        rec[v][`AT_OFS_EXPECT + i] = exp_v[v][8*i +: 8];
      end
      for (int i = 0; i < 10; i++) begin
        rec[v][`AT_OFS_KEY + i] = key_v[v][8*i +: 8];
      end
      rec[v][`AT_OFS_DIR] = {7'd0, dec_v[v]};
    end
  endtask

  task automatic fill_sd();
    for (int b = 0; b < 8; b++) begin
      for (int i = 0; i < `AT_SD_BLOCK_BYTES; i++) begin
        if (b < NVEC && i < 32) begin
          u_sd.mem[b][i] = rec[b][i];
        end else begin
          u_sd.mem[b][i] = 8'((i * 7) ^ (i >> 5) ^ (b * 29));
        end
      end
    end
  endtask

  task automatic check_write_back(input int v);
    logic [63:0] res;
    logic [7:0]  expb;
    res = cipher_model(blk_v[v], key_v[v], dec_v[v]);
    for (int i = 0; i < `AT_SD_BLOCK_BYTES; i++) begin
      if (i < 32) begin
        expb = rec[v][i];
      end else if (i < `AT_OFS_TIME) begin
        expb = res[8*(i-`AT_OFS_RESULT) +: 8];
      end else if (i < `AT_OFS_END) begin
        expb = 8'(64'(dly_v[v]) >> (8 * (i - `AT_OFS_TIME)));
      end else begin
        expb = 8'hFF;
      end
      assert (u_sd.mem[v][i] == expb)
        else report_mismatch($sformatf("write_back[%0d]", i), 128'(expb), 128'(u_sd.mem[v][i]));
    end
  endtask

  initial begin
    void'($urandom(86));
    rst = 1'b1;
    dbg_sel = autotest_pkg::DBG_STATUS;
    uut_result = '0;
    uut_end_enc = 1'b0;
    uut_end_dec = 1'b0;
    vec_idx = 0;
    run_cnt = 0;
    cycle_cnt = 0;
    wr_blocks = 0;
    err_total = 0;
    fail_cnt = 0;
    w_block_d = 1'b0;
    build_vectors();
    fill_sd();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int v = 0; v < NVEC; v++) begin
      vec_idx = v;
      while (!spi_r_block) next_cycle();
      assert (spi_addr == `AT_START_BLOCK + v)
        else report_mismatch("read_address", 128'(`AT_START_BLOCK + v), 128'(spi_addr));
      if (v < NVEC - 1) begin
        while (uut_rst) next_cycle();
        assert (uut_block == blk_v[v])
          else report_mismatch("uut_block", 128'(blk_v[v]), 128'(uut_block));
        assert (uut_key == key_v[v])
          else report_mismatch("uut_key", 128'(key_v[v]), 128'(uut_key));
        assert (uut_decrypt == dec_v[v])
          else report_mismatch("uut_decrypt", 128'(dec_v[v]), 128'(uut_decrypt));
        // uut reset stays low through any write-back
        while (!uut_rst) next_cycle();
        if (bad_exp[v]) begin
          err_total++;
          check_write_back(v);
        end
        assert (wr_blocks == err_total)
          else report_mismatch("block_writes", 128'(err_total), 128'(wr_blocks));
      end
    end
    while (dbg[4:0] != autotest_pkg::HALT) next_cycle();
    dbg_sel = autotest_pkg::DBG_ERRORS;
    next_cycle();
    assert (dbg == 32'(err_total))
      else report_mismatch("error_count", 128'(err_total), 128'(dbg));
    repeat (30) next_cycle();
    if (fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== autotest.f ====
+incdir+design
design/autotest_pkg.sv
design/vector_store.sv
design/autotest_ctrl.sv
design/autotest_top.sv
testbench/sd_host_model.sv
testbench/autotest_props.sv
testbench/tb_autotest.sv

// ==== Makefile ====
TOP := tb_autotest
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, result from $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f autotest.f -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if grep -q "%Error" $(LOG); then echo "assertion or runtime error"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "no pass result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
